// File: astral_chip_top.sv
////////////////////////////////////////
// chip wrapper infrastructure top level
// reset sync, rt clock divider, padframe
// config registers and pad multiplexer
////////////////////////////////////////

`timescale 1ns/1ns

module astral_chip_top #(
  parameter int unsigned SyncStages = 2,
  parameter int unsigned DivValue   = 100
) (
  input  logic                                                 ref_clk_i,
  input  logic                                                 rst_n_i,
  output logic                                                 ref_rst_n_o,
  output logic                                                 rt_clk_o,
  input  astral_pkg::cfg_req_t                                 cfg_req_i,
  output astral_pkg::cfg_rsp_t                                 cfg_rsp_o,
  input  astral_pkg::pad_drive_t [astral_pkg::NumPadFuncs-1:0] func_drive_i,
  output astral_pkg::pad_lanes_t [astral_pkg::NumPadFuncs-1:0] func_in_o,
  output astral_pkg::pad_lanes_t                               pad_o,
  output astral_pkg::pad_lanes_t                               pad_oe_o,
  input  astral_pkg::pad_lanes_t                               pad_i
);
  import astral_pkg::*;

  logic     ref_rst_n;
  pad_sel_t pad_sel;

  // power-on reset into the ref clock domain
  por_rst_sync #(
    .SyncStages ( SyncStages )
  ) i_por_rst_sync (
    .ref_clk_i ( ref_clk_i ),
    .rst_n_i   ( rst_n_i   ),
    .rst_n_o   ( ref_rst_n )
  );

  assign ref_rst_n_o = ref_rst_n;

  rt_clk_div #(
    .DivValue ( DivValue )
  ) i_rt_clk_div (
    .ref_clk_i ( ref_clk_i ),
    .rst_n_i   ( ref_rst_n ),
    .clk_o     ( rt_clk_o  )
  );

  ////////////////////////////////////////
  // padframe
  ////////////////////////////////////////

  pad_cfg_regs i_pad_cfg_regs (
    .ref_clk_i ( ref_clk_i ),
    .rst_n_i   ( ref_rst_n ),
    .cfg_req_i ( cfg_req_i ),
    .cfg_rsp_o ( cfg_rsp_o ),
    .pad_sel_o ( pad_sel   )
  );

  pad_mux i_pad_mux (
    .pad_sel_i    ( pad_sel      ),
    .func_drive_i ( func_drive_i ),
    .pad_i        ( pad_i        ),
    .pad_o        ( pad_o        ),
    .pad_oe_o     ( pad_oe_o     ),
    .func_in_o    ( func_in_o    )
  );

  // mux has no clock of its own, sample its ownership check here
  assert property (@(posedge ref_clk_i) disable iff (!ref_rst_n)
    !i_pad_mux.func_in_leak)
    else $error("pad input returned to a function that does not own the pad");

endmodule

// File: astral_pkg.sv
////////////////////////////////////////
// shared pad count and function encoding
// configuration request and response
// pad drive and pad lane types
////////////////////////////////////////

package astral_pkg;

  ////////////////////////////////////////
  // padframe dimensions
  ////////////////////////////////////////

  // fixed for the chip
  localparam int unsigned NumMuxPads  = 22;
  localparam int unsigned NumPadFuncs = 4;

  // owner of a multiplexed pad
  typedef enum logic [1:0] {
    PadFuncGpio = 2'd0,
    PadFuncSpi  = 2'd1,
    PadFuncI2c  = 2'd2,
    PadFuncCan  = 2'd3
  } pad_func_e;

  // one owner per pad, pad 0 in the low bits
  typedef pad_func_e [NumMuxPads-1:0] pad_sel_t;

  ////////////////////////////////////////
  // configuration port
  ////////////////////////////////////////

  localparam int unsigned CfgAddrW = 5;
  localparam int unsigned CfgDataW = 32;

  // single-cycle strobe, no ready
  typedef struct packed {
    logic                valid;
    logic                write;
    logic [CfgAddrW-1:0] addr;
    logic [CfgDataW-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic                valid;
    logic                error;
    logic [CfgDataW-1:0] rdata;
  } cfg_rsp_t;

  ////////////////////////////////////////
  // pad lanes
  ////////////////////////////////////////

  typedef logic [NumMuxPads-1:0] pad_lanes_t;

  // what one function wants on every pad lane
  typedef struct packed {
    pad_lanes_t o;
    pad_lanes_t oe;
  } pad_drive_t;

endpackage

// File: pad_cfg_regs.sv
////////////////////////////////////////
// per-pad function select registers
// behind the configuration port
////////////////////////////////////////

`timescale 1ns/1ns

module pad_cfg_regs (
  input  logic                 ref_clk_i,
  input  logic                 rst_n_i,
  input  astral_pkg::cfg_req_t cfg_req_i,
  output astral_pkg::cfg_rsp_t cfg_rsp_o,
  output astral_pkg::pad_sel_t pad_sel_o
);
  import astral_pkg::*;

  pad_sel_t            sel_q;
  logic                addr_ok;
  logic                wr_en;
  logic [CfgDataW-1:0] rd_data;
  logic                rsp_valid_q;
  logic                rsp_error_q;
  logic [CfgDataW-1:0] rsp_rdata_q;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  // one word per pad, nothing above
  assign addr_ok = cfg_req_i.addr < CfgAddrW'(NumMuxPads);
  assign wr_en   = cfg_req_i.valid & cfg_req_i.write & addr_ok;

  // select in bits 1:0, writes answer with zero
  always_comb begin
    rd_data = '0;
    if (cfg_req_i.valid && !cfg_req_i.write && addr_ok) begin
      rd_data[1:0] = sel_q[cfg_req_i.addr];
    end
  end

  ////////////////////////////////////////
  // select registers
  ////////////////////////////////////////

  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NumMuxPads; i++) begin
        sel_q[i] <= PadFuncGpio;
      end
    end else if (wr_en) begin
      sel_q[cfg_req_i.addr] <= pad_func_e'(cfg_req_i.wdata[1:0]);
    end
  end

  assign pad_sel_o = sel_q;

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= cfg_req_i.valid;
    end
  end

  always_ff @(posedge ref_clk_i) begin
    rsp_error_q <= ~addr_ok;
    rsp_rdata_q <= rd_data;
  end

  assign cfg_rsp_o = '{valid: rsp_valid_q, error: rsp_error_q, rdata: rsp_rdata_q};

  // fixed one-cycle latency both ways
  // a request on the release edge is still seen in reset
  assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
    (cfg_req_i.valid && rst_n_i) |=> cfg_rsp_o.valid)
    else $error("config request without response one cycle later");

  assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
    cfg_rsp_o.valid |-> $past(cfg_req_i.valid))
    else $error("config response without request one cycle earlier");

endmodule

// File: pad_mux.sv
////////////////////////////////////////
// pad multiplexer, function drives out
// and pad inputs back to the owner
////////////////////////////////////////

`timescale 1ns/1ns

module pad_mux (
  input  astral_pkg::pad_sel_t                                 pad_sel_i,
  input  astral_pkg::pad_drive_t [astral_pkg::NumPadFuncs-1:0] func_drive_i,
  input  astral_pkg::pad_lanes_t                               pad_i,
  output astral_pkg::pad_lanes_t                               pad_o,
  output astral_pkg::pad_lanes_t                               pad_oe_o,
  output astral_pkg::pad_lanes_t [astral_pkg::NumPadFuncs-1:0] func_in_o
);
  import astral_pkg::*;

  logic func_in_leak;

  ////////////////////////////////////////
  // routing
  ////////////////////////////////////////

  always_comb begin
    pad_o     = '0;
    pad_oe_o  = '0;
    // functions that do not own a pad see zero on it
    func_in_o = '0;
    for (int p = 0; p < NumMuxPads; p++) begin
      pad_o[p]                   = func_drive_i[pad_sel_i[p]].o[p];
      pad_oe_o[p]                = func_drive_i[pad_sel_i[p]].oe[p];
      func_in_o[pad_sel_i[p]][p] = pad_i[p];
    end
  end

  ////////////////////////////////////////
  // ownership check
  ////////////////////////////////////////

  // set when any function sees a one on a pad it does not own
  always_comb begin
    func_in_leak = 1'b0;
    for (int f = 0; f < NumPadFuncs; f++) begin
      for (int p = 0; p < NumMuxPads; p++) begin
        if (func_in_o[f][p] && (pad_sel_i[p] != pad_func_e'(f))) begin
          func_in_leak = 1'b1;
        end
      end
    end
  end

endmodule

// File: por_rst_sync.sv
////////////////////////////////////////
// power-on reset synchroniser
////////////////////////////////////////

`timescale 1ns/1ns

module por_rst_sync #(
  parameter int unsigned SyncStages = 2
) (
  input  logic ref_clk_i,
  input  logic rst_n_i,
  output logic rst_n_o
);

  logic                  rst_smp_q;
  logic [SyncStages-1:0] sync_q;

  // pad sample feeding the chain
  always_ff @(posedge ref_clk_i) begin
    rst_smp_q <= rst_n_i;
  end

  // clears at once, fills with ones one stage per cycle
  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= rst_smp_q;
      for (int i = 1; i < SyncStages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign rst_n_o = sync_q[SyncStages-1];

  // release is delayed, assertion is not
  assert property (@(posedge ref_clk_i) !rst_n_i |=> !rst_n_o)
    else $error("synchronised reset high right after reset pad sampled low");

endmodule

// File: project.f
astral_pkg.sv
por_rst_sync.sv
rt_clk_div.sv
pad_cfg_regs.sv
pad_mux.sv
astral_chip_top.sv
tb_astral_checker.sv
tb_astral_chip.sv

// File: rt_clk_div.sv
////////////////////////////////////////
// static integer divider for the
// real-time clock
////////////////////////////////////////

`timescale 1ns/1ns

module rt_clk_div #(
  parameter int unsigned DivValue = 100
) (
  input  logic ref_clk_i,
  input  logic rst_n_i,
  output logic clk_o
);

  localparam int unsigned CntW       = $clog2(DivValue);
  localparam int unsigned HighCycles = DivValue / 2;
  localparam int unsigned LowCycles  = DivValue - HighCycles;

  logic [CntW-1:0] cnt_q;
  logic [CntW-1:0] cnt_d;
  logic            clk_q;

  // wraps at DivValue
  assign cnt_d = (cnt_q == CntW'(DivValue - 1)) ? '0 : cnt_q + 1'b1;

  // low phase first, output comes straight from a flop
  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
      clk_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      clk_q <= (cnt_d >= CntW'(LowCycles));
    end
  end

  assign clk_o = clk_q;

  initial begin
    assert (DivValue >= 2)
      else $fatal(1, "rt_clk_div needs DivValue of at least 2");
  end

  assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
    $rose(clk_o) |-> ##HighCycles $fell(clk_o))
    else $error("rt clock high phase has wrong length");

  assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
    $fell(clk_o) |-> ##LowCycles $rose(clk_o))
    else $error("rt clock low phase has wrong length");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the chip wrapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_astral_chip -f project.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_astral_chip > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "All checks passed" "$log_file"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

// File: tb_astral_checker.sv
////////////////////////////////////////
// testbench checker with reference model
// of reset, config registers, pad routing
// and real-time clock
////////////////////////////////////////

`timescale 1ns/1ns

module tb_astral_checker #(
  parameter int unsigned SyncStages = 2,
  parameter int unsigned DivValue   = 100
) (
  input logic                                                 clk_i,
  input logic                                                 rst_n_i,
  input logic                                                 ref_rst_n_i,
  input logic                                                 rt_clk_i,
  input astral_pkg::cfg_req_t                                 cfg_req_i,
  input astral_pkg::cfg_rsp_t                                 cfg_rsp_i,
  input astral_pkg::pad_drive_t [astral_pkg::NumPadFuncs-1:0] func_drive_i,
  input astral_pkg::pad_lanes_t [astral_pkg::NumPadFuncs-1:0] func_in_i,
  input astral_pkg::pad_lanes_t                               pad_out_i,
  input astral_pkg::pad_lanes_t                               pad_oe_i,
  input astral_pkg::pad_lanes_t                               pad_in_i
);
  import astral_pkg::*;

  localparam int unsigned LowCycles = DivValue - DivValue / 2;

  // model state as it stands after the last rising edge
  int unsigned         edges       = 0;
  int unsigned         high_run    = 0;
  logic                rst_m       = 1'b0;
  logic                sel_known   = 1'b0;
  pad_func_e           sel_m [NumMuxPads];
  logic                rsp_valid_m = 1'b0;
  logic                rsp_error_m = 1'b0;
  logic                rsp_read_m  = 1'b0;
  logic [CfgDataW-1:0] rsp_rdata_m = '0;
  int unsigned         phase       = 0;
  logic                rtc_m       = 1'b0;
  int unsigned         rsp_seen    = 0;
  // reset, config, routing, input return, rt clock
  int unsigned         errs [5]    = '{default: 0};

  task automatic mismatch(input int unsigned kind, input string test,
                          input logic [63:0] exp_val, input logic [63:0] act_val);
    errs[kind]++;
    $display("error %s: expected %h, actual %h at %0t", test, exp_val, act_val, $time);
  endtask

  always @(negedge clk_i) begin
    pad_lanes_t owned [NumPadFuncs];
    pad_lanes_t exp_o;
    pad_lanes_t exp_oe;
    pad_lanes_t exp_in;
    logic       in_range;
    ////////////////////////////////////////
    // compare outputs with the model
    ////////////////////////////////////////
    if (edges > 0 && ref_rst_n_i !== rst_m) begin
      mismatch(0, "reset", 64'(rst_m), 64'(ref_rst_n_i));
    end
    if (sel_known) begin
      for (int f = 0; f < NumPadFuncs; f++) begin
        for (int p = 0; p < NumMuxPads; p++) begin
          owned[f][p] = (sel_m[p] == pad_func_e'(f));
        end
      end
      exp_o  = '0;
      exp_oe = '0;
      for (int f = 0; f < NumPadFuncs; f++) begin
        exp_o  = exp_o | (func_drive_i[f].o & owned[f]);
        exp_oe = exp_oe | (func_drive_i[f].oe & owned[f]);
        // owner sees the pad, everyone else zero
        exp_in = pad_in_i & owned[f];
        if (func_in_i[f] !== exp_in) begin
          mismatch(3, "input_return", 64'(exp_in), 64'(func_in_i[f]));
        end
      end
      if (pad_out_i !== exp_o) begin
        mismatch(2, "output_routing", 64'(exp_o), 64'(pad_out_i));
      end
      if (pad_oe_i !== exp_oe) begin
        mismatch(2, "output_enable_routing", 64'(exp_oe), 64'(pad_oe_i));
      end
      if (cfg_rsp_i.valid !== rsp_valid_m) begin
        mismatch(1, "cfg_rsp_valid", 64'(rsp_valid_m), 64'(cfg_rsp_i.valid));
      end else if (rsp_valid_m) begin
        rsp_seen++;
        if (cfg_rsp_i.error !== rsp_error_m) begin
          mismatch(1, "cfg_rsp_error", 64'(rsp_error_m), 64'(cfg_rsp_i.error));
        end
        if ((rsp_read_m || rsp_error_m) && cfg_rsp_i.rdata !== rsp_rdata_m) begin
          mismatch(1, "cfg_rsp_rdata", 64'(rsp_rdata_m), 64'(cfg_rsp_i.rdata));
        end
      end
      if (rt_clk_i !== rtc_m) begin
        mismatch(4, "rt_clock", 64'(rtc_m), 64'(rt_clk_i));
      end
    end
    ////////////////////////////////////////
    // step the model over the next edge
    ////////////////////////////////////////
    if (edges > 0 && !rst_m) begin
      for (int p = 0; p < NumMuxPads; p++) begin
        sel_m[p] = PadFuncGpio;
      end
      sel_known   = 1'b1;
      rsp_valid_m = 1'b0;
      phase       = 0;
      rtc_m       = 1'b0;
    end else if (sel_known) begin
      rsp_valid_m = cfg_req_i.valid;
      if (cfg_req_i.valid) begin
        in_range    = 32'(cfg_req_i.addr) < NumMuxPads;
        rsp_error_m = !in_range;
        rsp_read_m  = !cfg_req_i.write;
        rsp_rdata_m = '0;
        if (in_range && !cfg_req_i.write) begin
          rsp_rdata_m[1:0] = sel_m[cfg_req_i.addr];
        end
        if (in_range && cfg_req_i.write) begin
          sel_m[cfg_req_i.addr] = pad_func_e'(cfg_req_i.wdata[1:0]);
        end
      end
      // low phase first, then high
      phase = (phase + 1) % DivValue;
      rtc_m = (phase >= LowCycles);
    end
    // release needs SyncStages edges after the first high sample
    if (rst_n_i) begin
      if (high_run <= SyncStages) begin
        high_run++;
      end
    end else begin
      high_run = 0;
    end
    rst_m = (high_run > SyncStages);
    edges++;
  end

  task automatic finish_report(output int unsigned total);
    if (rsp_seen == 0) begin
      $display("no configuration response was ever checked");
      errs[1]++;
    end
    total = errs[0] + errs[1] + errs[2] + errs[3] + errs[4];
    $display("errors: reset %0d, config %0d, routing %0d, input return %0d, rt clock %0d",
             errs[0], errs[1], errs[2], errs[3], errs[4]);
  endtask

endmodule

// File: tb_astral_chip.sv
////////////////////////////////////////
// testbench top for the chip wrapper
// clock, reset, random stimulus, timeout
////////////////////////////////////////

`timescale 1ns/1ns

module tb_astral_chip;
  import astral_pkg::*;

  localparam int unsigned SyncStages  = 2;
  localparam int unsigned DivValue    = 10;
  localparam int unsigned ClkHalf     = 5;
  localparam int unsigned ResetCycles = 8;
  localparam int unsigned RandCycles  = 2000;
  localparam int unsigned QuietCycles = 20;
  localparam int unsigned MidReset    = RandCycles / 2;
  // random traffic plus both resets, with slack
  localparam int unsigned MaxCycles   = RandCycles * 3 / 2;
  localparam logic [31:0] Seed        = 32'hd02a_5c3c;

  logic                         ref_clk = 1'b0;
  logic                         rst_n;
  logic                         ref_rst_n;
  logic                         rt_clk;
  cfg_req_t                     cfg_req;
  cfg_rsp_t                     cfg_rsp;
  pad_drive_t [NumPadFuncs-1:0] func_drive;
  pad_lanes_t [NumPadFuncs-1:0] func_in;
  pad_lanes_t                   pad_out;
  pad_lanes_t                   pad_oe;
  pad_lanes_t                   pad_in;
  logic [31:0]                  rng_state;
  int unsigned                  cycle_cnt = 0;
  int unsigned                  errs;

  always #(ClkHalf) ref_clk = ~ref_clk;

  astral_chip_top #(
    .SyncStages ( SyncStages ),
    .DivValue   ( DivValue   )
  ) i_dut (
    .ref_clk_i    ( ref_clk    ),
    .rst_n_i      ( rst_n      ),
    .ref_rst_n_o  ( ref_rst_n  ),
    .rt_clk_o     ( rt_clk     ),
    .cfg_req_i    ( cfg_req    ),
    .cfg_rsp_o    ( cfg_rsp    ),
    .func_drive_i ( func_drive ),
    .func_in_o    ( func_in    ),
    .pad_o        ( pad_out    ),
    .pad_oe_o     ( pad_oe     ),
    .pad_i        ( pad_in     )
  );

  tb_astral_checker #(
    .SyncStages ( SyncStages ),
    .DivValue   ( DivValue   )
  ) i_checker (
    .clk_i        ( ref_clk    ),
    .rst_n_i      ( rst_n      ),
    .ref_rst_n_i  ( ref_rst_n  ),
    .rt_clk_i     ( rt_clk     ),
    .cfg_req_i    ( cfg_req    ),
    .cfg_rsp_i    ( cfg_rsp    ),
    .func_drive_i ( func_drive ),
    .func_in_i    ( func_in    ),
    .pad_out_i    ( pad_out    ),
    .pad_oe_i     ( pad_oe     ),
    .pad_in_i     ( pad_in     )
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // one cycle of random traffic
  task automatic drive_cycle(input logic allow_req);
    logic [31:0]                  r;
    cfg_req_t                     req;
    pad_drive_t [NumPadFuncs-1:0] drv;
    r   = next_rand();
    req = '0;
    if (allow_req && r[0]) begin
      req.valid = 1'b1;
      // three writes to one read
      req.write = r[1] | r[2];
      req.addr  = r[7:3];
      req.wdata = next_rand();
    end
    for (int f = 0; f < NumPadFuncs; f++) begin
      drv[f].o  = pad_lanes_t'(next_rand());
      drv[f].oe = pad_lanes_t'(next_rand());
    end
    cfg_req    <= req;
    func_drive <= drv;
    pad_in     <= pad_lanes_t'(next_rand());
  endtask

  initial begin
    rng_state = Seed;
    rst_n      <= 1'b0;
    cfg_req    <= '0;
    func_drive <= '0;
    pad_in     <= '0;
    repeat (ResetCycles) @(posedge ref_clk);
    rst_n <= 1'b1;
    for (int i = 0; i < RandCycles; i++) begin
      @(posedge ref_clk);
      // mid-run reset pulse
      if (i == MidReset) begin
        rst_n <= 1'b0;
      end
      if (i == MidReset + ResetCycles) begin
        rst_n <= 1'b1;
      end
      drive_cycle(i >= QuietCycles);
    end
    @(posedge ref_clk);
    cfg_req <= '0;
    // let the last response drain
    repeat (4) @(posedge ref_clk);
    i_checker.finish_report(errs);
    if (errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  always @(posedge ref_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      $display("timeout, the run did not finish within %0d cycles", MaxCycles);
      $display("Checks failed");
      $finish;
    end
  end

endmodule
